// ==== design/preamble_pkg.sv ====
`default_nettype none

package preamble_pkg;

  localparam int DATA_WIDTH = 16;
  localparam int MAX_LEN    = 256;

  // one component of x[n] * conj(x[n-LEN]) or of i*i + q*q.
  localparam int PROD_WIDTH = 2 * DATA_WIDTH + 1;

  localparam int ACC_WIDTH  = PROD_WIDTH + $clog2(MAX_LEN);
  localparam int MAG_WIDTH  = ACC_WIDTH + 1;  // headroom for max + min/2.

  typedef logic signed [DATA_WIDTH-1:0] sample_t;

  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_t;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  typedef struct packed {
    acc_t i;
    acc_t q;
  } cacc_t;

  typedef logic [MAG_WIDTH-1:0] mag_t;

  // fraction of the power magnitude that the correlation magnitude must exceed.
  typedef enum logic [1:0] {
    THR_1_4 = 2'b00,
    THR_3_8 = 2'b01,
    THR_1_2 = 2'b10,
    THR_5_8 = 2'b11
  } thres_e;

endpackage

`default_nettype wire

// ==== design/iq_stream_if.sv ====
`default_nettype none

interface iq_stream_if
  import preamble_pkg::*;
();

  logic valid;
  logic ready;
  logic last;
  iq_t  cur;  // newest sample.
  iq_t  dly;  // sample LEN positions earlier.

  modport source (output valid, output last, output cur, output dly, input ready);
  modport sink   (input valid, input last, input cur, input dly, output ready);

endinterface

interface acc_stream_if
  import preamble_pkg::*;
();

  logic  valid;
  logic  ready;
  logic  last;
  cacc_t acorr;  // windowed autocorrelation.
  acc_t  pow;    // windowed signal power.

  modport source (output valid, output last, output acorr, output pow, input ready);
  modport sink   (input valid, input last, input acorr, input pow, output ready);

endinterface

`default_nettype wire

// ==== design/iq_delay_line.sv ====
`default_nettype none

module iq_delay_line
  import preamble_pkg::*;
#(
  parameter int LEN = 16
) (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_clear,

  input  logic        i_valid,
  input  logic        i_last,
  input  iq_t         i_sample,
  output logic        o_ready,

  iq_stream_if.source out
);

  localparam int PTR_W = (LEN > 1) ? $clog2(LEN) : 1;

  iq_t              ring [LEN];
  logic [PTR_W-1:0] wr_ptr;
  logic             primed;
  logic             run_en;
  logic             accept;
  logic             wrap;

  // the output register can take a sample when it is empty or being drained.
  assign o_ready = run_en && !i_clear && (!out.valid || out.ready);
  assign accept  = i_valid && o_ready;
  assign wrap    = (wr_ptr == PTR_W'(LEN - 1));

  always_ff @(posedge clk) begin
    run_en <= !i_rst;  // holds the input off while reset is asserted.
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      wr_ptr    <= '0;
      primed    <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr    <= wrap ? '0 : wr_ptr + 1'b1;
        out.valid <= 1'b1;
        if (wrap) begin
          primed <= 1'b1;  // from now on the ring holds real history.
        end
      end else if (out.ready) begin
        out.valid <= 1'b0;
      end
    end
  end

  // The slot about to be overwritten holds the sample from LEN inputs ago.
  always_ff @(posedge clk) begin
    if (accept) begin
      ring[wr_ptr] <= i_sample;
      out.cur      <= i_sample;
      out.dly      <= primed ? ring[wr_ptr] : '0;
      out.last     <= i_last;
    end
  end

  a_ptr_in_range : assert property (
    @(posedge clk) disable iff (i_rst)
    wr_ptr <= PTR_W'(LEN - 1)
  );

endmodule

`default_nettype wire

// ==== design/corr_accumulator.sv ====
`default_nettype none

module corr_accumulator
  import preamble_pkg::*;
#(
  parameter int LEN = 16
) (
  input  logic         clk,
  input  logic         i_rst,
  input  logic         i_clear,

  iq_stream_if.sink    in,
  acc_stream_if.source out
);

  localparam int PTR_W = (LEN > 1) ? $clog2(LEN) : 1;
  localparam int CNT_W = $clog2(LEN + 1);

  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  typedef struct packed {
    prod_t i;  // real part of the conjugate product.
    prod_t q;  // imaginary part of the conjugate product.
    prod_t p;  // instantaneous power.
  } term_t;

  // The sums only have log2(MAX_LEN) bits of growth.
  if (LEN < 1 || LEN > MAX_LEN) begin : g_len_check
    $error("corr_accumulator LEN must lie between 1 and MAX_LEN");
  end

  prod_t            ci;
  prod_t            cq;
  prod_t            di;
  prod_t            dq;
  term_t            term_d;
  term_t            term_q;
  term_t            term_old;
  term_t            ring [LEN];
  logic [PTR_W-1:0] ptr;
  logic [CNT_W-1:0] fill;
  logic             p_valid;
  logic             p_last;
  logic             advance;
  logic             in_fire;

  assign ci = prod_t'(in.cur.i);
  assign cq = prod_t'(in.cur.q);
  assign di = prod_t'(in.dly.i);
  assign dq = prod_t'(in.dly.q);

  // (ci + j cq) * (di - j dq).
  always_comb begin
    term_d.i = ci * di + cq * dq;
    term_d.q = cq * di - ci * dq;
    term_d.p = ci * ci + cq * cq;
  end

  // the product stage moves on only when the window stage can take its item.
  assign advance  = p_valid && (!out.valid || out.ready);
  assign in.ready = !p_valid || advance;
  assign in_fire  = in.valid && in.ready;

  // Until the window is full the term leaving it is zero.
  assign term_old = (fill == CNT_W'(LEN)) ? ring[ptr] : '0;

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      p_valid <= 1'b0;
    end else if (in_fire) begin
      p_valid <= 1'b1;
    end else if (advance) begin
      p_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      term_q <= term_d;
      p_last <= in.last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      out.valid   <= 1'b0;
      out.acorr   <= '0;
      out.pow     <= '0;
      ptr         <= '0;
      fill        <= '0;
    end else if (advance) begin
      out.valid   <= 1'b1;
      out.acorr.i <= out.acorr.i + acc_t'(term_q.i) - acc_t'(term_old.i);
      out.acorr.q <= out.acorr.q + acc_t'(term_q.q) - acc_t'(term_old.q);
      out.pow     <= out.pow + acc_t'(term_q.p) - acc_t'(term_old.p);
      ptr         <= (ptr == PTR_W'(LEN - 1)) ? '0 : ptr + 1'b1;
      if (fill != CNT_W'(LEN)) begin
        fill <= fill + 1'b1;
      end
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ring[ptr] <= term_q;  // replaces the term that just left the window.
      out.last  <= p_last;
    end
  end

  a_hold_payload : assert property (
    @(posedge clk) disable iff (i_rst || i_clear)
    out.valid && !out.ready |=>
      out.valid && $stable(out.acorr) && $stable(out.pow) && $stable(out.last)
  );

endmodule

`default_nettype wire

// ==== design/peak_detector.sv ====
`default_nettype none

module peak_detector
  import preamble_pkg::*;
#(
  parameter int          NRX_TRIG  = 4,
  parameter thres_e      THRES_SEL = THR_1_2,
  parameter int unsigned NOISE_POW = 200
) (
  input  logic         clk,
  input  logic         i_rst,
  input  logic         i_clear,

  acc_stream_if.sink   in,

  output logic         o_valid,
  output logic         o_last,
  output logic         o_peak,
  output mag_t         o_acorr_mag,
  output mag_t         o_pow_mag,
  input  logic         i_ready
);

  localparam int   CNT_W     = $clog2(NRX_TRIG + 1);
  localparam mag_t NOISE_MAG = mag_t'(NOISE_POW);

  logic signed [MAG_WIDTH-1:0] si;
  logic signed [MAG_WIDTH-1:0] sq;
  mag_t                        ai;
  mag_t                        aq;
  mag_t                        acorr_mag;
  mag_t                        pow_mag;
  mag_t                        thresh;
  logic                        trig;
  logic                        hit;
  logic                        fire;
  logic [CNT_W-1:0]            run_cnt;

  always_comb begin
    si        = MAG_WIDTH'(in.acorr.i);
    sq        = MAG_WIDTH'(in.acorr.q);
    ai        = si[MAG_WIDTH-1] ? mag_t'(-si) : mag_t'(si);
    aq        = sq[MAG_WIDTH-1] ? mag_t'(-sq) : mag_t'(sq);
    acorr_mag = (ai > aq) ? ai + (aq >> 1) : aq + (ai >> 1);  // max plus half of min.
    pow_mag   = mag_t'(in.pow);
  end

  always_comb begin
    case (THRES_SEL)
      THR_1_4: thresh = pow_mag >> 2;
      THR_3_8: thresh = (pow_mag >> 2) + (pow_mag >> 3);
      THR_1_2: thresh = pow_mag >> 1;
      default: thresh = (pow_mag >> 1) + (pow_mag >> 3);
    endcase
  end

  assign trig     = (acorr_mag > thresh) && (pow_mag > NOISE_MAG) && (acorr_mag > NOISE_MAG);
  assign hit      = trig && (run_cnt == CNT_W'(NRX_TRIG - 1));
  assign in.ready = !o_valid || i_ready;
  assign fire     = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      o_valid <= 1'b0;
      o_peak  <= 1'b0;
      run_cnt <= '0;
    end else if (fire) begin
      o_valid <= 1'b1;
      o_peak  <= hit;
      if (!trig) begin
        run_cnt <= '0;
      end else if (run_cnt != CNT_W'(NRX_TRIG)) begin
        run_cnt <= run_cnt + 1'b1;  // stops at NRX_TRIG so a long run strobes once.
      end
    end else if (i_ready) begin
      o_valid <= 1'b0;
      o_peak  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      o_last      <= in.last;
      o_acorr_mag <= acorr_mag;
      o_pow_mag   <= pow_mag;
    end
  end

  // a strobe marks the sample that completed a full run.
  a_peak_valid : assert property (
    @(posedge clk) disable iff (i_rst)
    o_peak |-> o_valid && (run_cnt == CNT_W'(NRX_TRIG))
  );

endmodule

`default_nettype wire

// ==== design/preamble_detect.sv ====
`default_nettype none

module preamble_detect
  import preamble_pkg::*;
#(
  parameter int          LEN       = 16,
  parameter int          NRX_TRIG  = 4,
  parameter thres_e      THRES_SEL = THR_1_2,
  parameter int unsigned NOISE_POW = 200
) (
  input  logic    clk,
  input  logic    i_rst,
  input  logic    i_clear,

  input  logic    i_valid,
  input  logic    i_last,
  input  sample_t i_i,
  input  sample_t i_q,
  output logic    o_in_ready,

  output logic    o_valid,
  output logic    o_last,
  output logic    o_peak,
  output mag_t    o_acorr_mag,
  output mag_t    o_pow_mag,
  input  logic    i_out_ready
);

  iq_stream_if  iq_link  ();
  acc_stream_if acc_link ();

  iq_delay_line #(
    .LEN (LEN)
  ) u_delay (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_clear  (i_clear),
    .i_valid  (i_valid),
    .i_last   (i_last),
    .i_sample ({i_i, i_q}),  // i in the upper half of iq_t.
    .o_ready  (o_in_ready),
    .out      (iq_link)
  );

  corr_accumulator #(
    .LEN (LEN)
  ) u_accum (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .in      (iq_link),
    .out     (acc_link)
  );

  peak_detector #(
    .NRX_TRIG  (NRX_TRIG),
    .THRES_SEL (THRES_SEL),
    .NOISE_POW (NOISE_POW)
  ) u_peak (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .in          (acc_link),
    .o_valid     (o_valid),
    .o_last      (o_last),
    .o_peak      (o_peak),
    .o_acorr_mag (o_acorr_mag),
    .o_pow_mag   (o_pow_mag),
    .i_ready     (i_out_ready)
  );

endmodule

`default_nettype wire

// ==== dv/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_mag(input string name, input mag_t got, input mag_t exp);
  if (got !== exp) begin
    stop_with_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_with_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    stop_with_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

task automatic wait_for_in_ready();
  int waited;
  waited = 0;
  @(posedge clk);
  while (!o_in_ready && waited < WAIT_LIMIT) begin
    waited++;
    @(posedge clk);
  end
  if (!o_in_ready) begin
    stop_with_failure("o_in_ready never rose after reset was released");
  end
endtask

task automatic wait_drained();
  int waited;
  waited = 0;
  while (exp_acorr.size() != 0 && waited < WAIT_LIMIT) begin
    waited++;
    @(posedge clk);
  end
  if (exp_acorr.size() != 0) begin
    stop_with_failure("expected outputs never left the DUT");
  end
endtask

`endif

// ==== dv/preamble_detect_tb.sv ====
`default_nettype none

module preamble_detect_tb
  import preamble_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int     LEN        = 16;
  localparam int     NRX_TRIG   = 4;
  localparam thres_e THRES_SEL  = THR_1_2;
  localparam int     NOISE_POW  = 200;
  localparam int     WAIT_LIMIT = 1000;

  logic    clk;
  logic    i_rst;
  logic    i_clear;
  logic    i_valid;
  logic    i_last;
  sample_t i_i;
  sample_t i_q;
  logic    o_in_ready;
  logic    o_valid;
  logic    o_last;
  logic    o_peak;
  mag_t    o_acorr_mag;
  mag_t    o_pow_mag;
  logic    i_out_ready;

  logic [31:0] lfsr_state;
  logic        bp_en;
  int          hist_i[$];
  int          hist_q[$];
  int          stim_i[$];
  int          stim_q[$];
  logic        stim_last[$];
  int          pat_i[LEN];
  int          pat_q[LEN];
  mag_t        exp_acorr[$];
  mag_t        exp_pow[$];
  logic        exp_peak[$];
  logic        exp_last[$];
  int          model_run;
  int          dut_peaks;

  preamble_detect #(
    .LEN       (LEN),
    .NRX_TRIG  (NRX_TRIG),
    .THRES_SEL (THRES_SEL),
    .NOISE_POW (NOISE_POW)
  ) dut (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_clear     (i_clear),
    .i_valid     (i_valid),
    .i_last      (i_last),
    .i_i         (i_i),
    .i_q         (i_q),
    .o_in_ready  (o_in_ready),
    .o_valid     (o_valid),
    .o_last      (o_last),
    .o_peak      (o_peak),
    .o_acorr_mag (o_acorr_mag),
    .o_pow_mag   (o_pow_mag),
    .i_out_ready (i_out_ready)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  // taps 32, 22, 2 and 1 give a maximal length sequence.
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int b = 0; b < count; b++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic longint hist_at(input int k, input logic q_part);
    if (k < 0) begin
      return 0;
    end
    return q_part ? longint'(hist_q[k]) : longint'(hist_i[k]);
  endfunction

  // The reference model builds each output from the whole history since reset or clear.
  function automatic void model_push(input int si, input int sq, input logic last);
    longint ci;
    longint cq;
    longint di;
    longint dq;
    longint ai;
    longint aq;
    longint pw;
    longint mi;
    longint mq;
    longint mag;
    longint thr;
    int     n;
    logic   trig;
    logic   peak;
    hist_i.push_back(si);
    hist_q.push_back(sq);
    n  = hist_i.size() - 1;
    ai = 0;
    aq = 0;
    pw = 0;
    for (int k = n - LEN + 1; k <= n; k++) begin
      ci = hist_at(k, 1'b0);
      cq = hist_at(k, 1'b1);
      di = hist_at(k - LEN, 1'b0);
      dq = hist_at(k - LEN, 1'b1);
      ai += ci * di + cq * dq;  // x[k] times conj(x[k-LEN]).
      aq += cq * di - ci * dq;
      pw += ci * ci + cq * cq;
    end
    mi  = (ai < 0) ? -ai : ai;
    mq  = (aq < 0) ? -aq : aq;
    mag = (mi > mq) ? mi + (mq >> 1) : mq + (mi >> 1);
    case (THRES_SEL)
      THR_1_4: thr = pw >> 2;
      THR_3_8: thr = (pw >> 2) + (pw >> 3);
      THR_1_2: thr = pw >> 1;
      default: thr = (pw >> 1) + (pw >> 3);
    endcase
    trig = (mag > thr) && (pw > NOISE_POW) && (mag > NOISE_POW);
    peak = 1'b0;
    if (!trig) begin
      model_run = 0;
    end else begin
      peak = (model_run == NRX_TRIG - 1);
      if (model_run < NRX_TRIG) begin
        model_run++;
      end
    end
    exp_acorr.push_back(mag_t'(mag));
    exp_pow.push_back(mag_t'(pw));
    exp_peak.push_back(peak);
    exp_last.push_back(last);
  endfunction

  task automatic check_output();
    if (exp_acorr.size() == 0) begin
      stop_with_failure("the DUT produced an output with no input left to match it");
    end else begin
      check_mag("o_acorr_mag", o_acorr_mag, exp_acorr.pop_front());
      check_mag("o_pow_mag", o_pow_mag, exp_pow.pop_front());
      check_bit("o_peak", o_peak, exp_peak.pop_front());
      check_bit("o_last", o_last, exp_last.pop_front());
      dut_peaks += int'(o_peak);
    end
  endtask

  always @(posedge clk) begin
    if (!i_rst && o_valid && i_out_ready) begin
      check_output();
    end
  end

  always @(negedge clk) begin
    i_out_ready = bp_en ? (take_bits(2) != 32'd0) : 1'b1;  // about one stall in four.
  end

  task automatic add_sample(input int si, input int sq, input logic last);
    stim_i.push_back(si);
    stim_q.push_back(sq);
    stim_last.push_back(last);
  endtask

  task automatic add_noise(input int count);
    int mi;
    int mq;
    for (int n = 0; n < count; n++) begin
      mi = int'(take_bits(2));
      mq = int'(take_bits(2));
      mi = take_bits(1) ? -mi : mi;
      mq = take_bits(1) ? -mq : mq;
      add_sample(mi, mq, 1'b0);
    end
  endtask

  task automatic make_pattern();
    for (int k = 0; k < LEN; k++) begin
      pat_i[k] = 2936 + int'(take_bits(7));
      pat_q[k] = 2936 + int'(take_bits(7));
      pat_i[k] = take_bits(1) ? -pat_i[k] : pat_i[k];
      pat_q[k] = take_bits(1) ? -pat_q[k] : pat_q[k];
    end
  endtask

  task automatic add_pattern(input int reps);
    for (int r = 0; r < reps; r++) begin
      for (int k = 0; k < LEN; k++) begin
        add_sample(pat_i[k], pat_q[k], 1'b0);
      end
    end
  endtask

  task automatic send_stim();
    int waited;
    for (int n = 0; n < stim_i.size(); n++) begin
      @(negedge clk);
      i_valid = 1'b1;
      i_i     = sample_t'(stim_i[n]);
      i_q     = sample_t'(stim_q[n]);
      i_last  = stim_last[n];
      waited  = 0;
      @(posedge clk);
      while (!o_in_ready && waited < WAIT_LIMIT) begin
        waited++;
        @(posedge clk);
      end
      if (!o_in_ready) begin
        stop_with_failure("an input sample was never accepted");
      end
      model_push(stim_i[n], stim_q[n], stim_last[n]);
    end
    @(negedge clk);
    i_valid = 1'b0;
    i_last  = 1'b0;
    stim_i.delete();
    stim_q.delete();
    stim_last.delete();
  endtask

  task automatic test_reset();
    for (int c = 0; c < 5; c++) begin
      @(negedge clk);
      check_bit("o_valid", o_valid, 1'b0);
      check_bit("o_peak", o_peak, 1'b0);
      check_bit("o_in_ready", o_in_ready, 1'b0);
    end
    i_rst = 1'b0;
    wait_for_in_ready();
    check_bit("o_valid", o_valid, 1'b0);
    check_bit("o_peak", o_peak, 1'b0);
  endtask

  task automatic test_noise();
    int peaks0;
    peaks0 = dut_peaks;
    add_noise(64);
    send_stim();
    wait_drained();
    repeat (8) @(posedge clk);
    check_count("noise o_peak strobes", dut_peaks - peaks0, 0);
  endtask

  task automatic test_preamble(input logic stall);
    int dut0;
    dut0 = dut_peaks;
    add_pattern(10);
    add_noise(32);
    bp_en = stall;
    send_stim();
    wait_drained();
    bp_en = 1'b0;
    repeat (8) @(posedge clk);
    check_count("o_peak strobes", dut_peaks - dut0, 1);  // the burst makes a single trigger run.
  endtask

  task automatic test_last_and_clear();
    add_noise(4);
    add_pattern(2);
    stim_last[10] = 1'b1;
    stim_last[stim_last.size() - 1] = 1'b1;
    send_stim();
    wait_drained();
    @(negedge clk);
    i_clear = 1'b1;
    @(negedge clk);
    check_bit("o_in_ready", o_in_ready, 1'b0);
    i_clear = 1'b0;
    hist_i.delete();  // the model starts again with empty history.
    hist_q.delete();
    model_run = 0;
    add_pattern(3);
    add_noise(8);
    stim_last[stim_last.size() - 1] = 1'b1;
    send_stim();
    wait_drained();
    repeat (8) @(posedge clk);
  endtask

  initial begin
    clk         = 1'b0;
    i_rst       = 1'b1;
    i_clear     = 1'b0;
    i_valid     = 1'b0;
    i_last      = 1'b0;
    i_i         = '0;
    i_q         = '0;
    i_out_ready = 1'b1;
    bp_en       = 1'b0;
    lfsr_state  = 32'ha54e9c51;
    model_run   = 0;
    dut_peaks   = 0;
    test_reset();
    test_noise();
    make_pattern();
    test_preamble(1'b0);
    test_preamble(1'b1);
    test_last_and_clear();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
design/preamble_pkg.sv
design/iq_stream_if.sv
design/iq_delay_line.sv
design/corr_accumulator.sv
design/peak_detector.sv
design/preamble_detect.sv
dv/preamble_detect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module preamble_detect_tb -o preamble_detect_sim > build.log 2>&1 \
  && ./obj_dir/preamble_detect_sim > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
